/* lc3b_control_rom.sv */
module lc3b_control_rom (
    input  lc3b_pkg::lc3b_instr i_instr,
    output lc3b_pkg::lc3b_ctrl  o_ctrl
);

    lc3b_pkg::lc3b_alumux_sel imm_or_reg;

    // Bit 5 picks imm5 over SR2 for ADD and AND
    assign imm_or_reg = i_instr.op.imm ? lc3b_pkg::mux_imm5 : lc3b_pkg::mux_reg;

    always_comb begin
        o_ctrl = '0;
        o_ctrl.opcode = i_instr.op.opcode;
        o_ctrl.aluop = lc3b_pkg::alu_pass;
        o_ctrl.alumux_sel = lc3b_pkg::mux_reg;

        case (i_instr.op.opcode)
            lc3b_pkg::op_add: begin
                o_ctrl.aluop = lc3b_pkg::alu_add;
                o_ctrl.alumux_sel = imm_or_reg;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc = 1'b1;
            end
            lc3b_pkg::op_and: begin
                o_ctrl.aluop = lc3b_pkg::alu_and;
                o_ctrl.alumux_sel = imm_or_reg;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc = 1'b1;
            end
            lc3b_pkg::op_not: begin
                o_ctrl.aluop = lc3b_pkg::alu_not;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc = 1'b1;
            end
            lc3b_pkg::op_ldr: begin
                // Base plus scaled offset6 gives the address
                o_ctrl.aluop = lc3b_pkg::alu_add;
                o_ctrl.alumux_sel = lc3b_pkg::mux_off6;
                o_ctrl.load_regfile = 1'b1;
                o_ctrl.load_cc = 1'b1;
                o_ctrl.d_mem_read = 1'b1;
            end
            lc3b_pkg::op_str: begin
                o_ctrl.aluop = lc3b_pkg::alu_add;
                o_ctrl.alumux_sel = lc3b_pkg::mux_off6;
                o_ctrl.d_mem_write = 1'b1;
                // Store source sits in the dest field
                o_ctrl.use_src2 = 1'b1;
            end
            default: begin
                // BR resolves in writeback, other opcodes do nothing
                o_ctrl.aluop = lc3b_pkg::alu_pass;
            end
        endcase
    end

endmodule

/* lc3b_datapath.sv */
`include "lc3b_settings.svh"

module lc3b_datapath (
    input  logic                    clk,
    input  logic                    i_rst_n,
    input  logic                    i_i_mem_resp,
    input  logic [`LC3B_WORD_W-1:0] i_i_mem_rdata,
    input  logic                    i_d_mem_resp,
    input  logic [`LC3B_WORD_W-1:0] i_d_mem_rdata,
    output logic                    o_i_mem_read,
    output logic [`LC3B_WORD_W-1:0] o_i_mem_address,
    output logic                    o_d_mem_read,
    output logic                    o_d_mem_write,
    output logic [`LC3B_WORD_W-1:0] o_d_mem_address,
    output logic [`LC3B_WORD_W-1:0] o_d_mem_wdata
);

    lc3b_pkg::lc3b_word  pc;
    lc3b_pkg::lc3b_word  pc_plus2;
    lc3b_pkg::lc3b_stage de_rec, ex_rec, mem_rec, wb_rec;
    lc3b_pkg::lc3b_stage fetch_out, decode_out, exec_out, memory_out;
    lc3b_pkg::lc3b_ctrl  de_ctrl;
    lc3b_pkg::lc3b_reg   de_src1, de_src2;
    lc3b_pkg::lc3b_word  de_src1_data, de_src2_data;
    lc3b_pkg::lc3b_word  ex_alu_out, ex_store_data, ex_br_target;
    lc3b_pkg::lc3b_word  d_rdata_q, mem_load_data, mem_result;
    logic                d_done, mem_busy, advance, br_enable, flush;

    wb_if  wb();
    fwd_if fwd();

    assign pc_plus2 = pc + lc3b_pkg::lc3b_word'(2);

    // Fetch
    always_comb begin
        fetch_out = '0;
        fetch_out.valid = 1'b1;
        fetch_out.instr = i_i_mem_rdata;
        fetch_out.pc_plus2 = pc_plus2;
    end

    // Decode
    lc3b_control_rom u_control_rom (.i_instr(de_rec.instr), .o_ctrl(de_ctrl));

    assign de_src1 = de_rec.instr.op.src1;
    assign de_src2 = de_ctrl.use_src2 ? de_rec.instr.op.dest : de_rec.instr.op.tail[2:0];

    lc3b_regfile u_regfile (
        .clk, .i_rst_n,
        .i_src1(de_src1), .i_src2(de_src2),
        .i_br_nzp(wb_rec.instr.br.nzp),
        .wb(wb),
        .o_src1_data(de_src1_data), .o_src2_data(de_src2_data),
        .o_br_enable(br_enable)
    );

    always_comb begin
        decode_out = de_rec;
        decode_out.ctrl = de_ctrl;
        decode_out.dest = de_rec.instr.op.dest;
        decode_out.src1 = de_src1;
        decode_out.src2 = de_src2;
        decode_out.src1_data = de_src1_data;
        decode_out.src2_data = de_src2_data;
    end

    // Execute
    lc3b_forwarding_unit u_forwarding_unit (.fwd(fwd));

    lc3b_execute u_execute (
        .i_rec(ex_rec), .fwd(fwd),
        .o_alu_out(ex_alu_out), .o_store_data(ex_store_data), .o_br_target(ex_br_target)
    );

    always_comb begin
        exec_out = ex_rec;
        exec_out.alu_out = ex_alu_out;
        exec_out.src2_data = ex_store_data;
        exec_out.addr = (ex_rec.ctrl.d_mem_read || ex_rec.ctrl.d_mem_write) ?
                        ex_alu_out : ex_br_target;
    end

    // Memory port, request dropped once answered while the pipe still waits
    assign o_d_mem_read = mem_rec.valid && mem_rec.ctrl.d_mem_read && !d_done;
    assign o_d_mem_write = mem_rec.valid && mem_rec.ctrl.d_mem_write && !d_done;
    assign o_d_mem_address = mem_rec.addr;
    assign o_d_mem_wdata = mem_rec.src2_data;
    assign mem_busy = o_d_mem_read || o_d_mem_write;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            d_done <= 1'b0;
        end else if (advance) begin
            d_done <= 1'b0;
        end else if (mem_busy && i_d_mem_resp) begin
            d_done <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (o_d_mem_read && i_d_mem_resp) begin
            d_rdata_q <= i_d_mem_rdata;
        end
    end

    assign mem_load_data = d_done ? d_rdata_q : i_d_mem_rdata;
    assign mem_result = mem_rec.ctrl.d_mem_read ? mem_load_data : mem_rec.alu_out;

    always_comb begin
        memory_out = mem_rec;
        memory_out.alu_out = mem_result;
    end

    // Writeback and branch resolution
    assign flush = wb_rec.valid && wb_rec.ctrl.opcode == lc3b_pkg::op_br && br_enable;
    assign advance = i_i_mem_resp && (!mem_busy || i_d_mem_resp);

    assign wb.valid = wb_rec.valid && advance;
    assign wb.load_regfile = wb_rec.ctrl.load_regfile;
    assign wb.load_cc = wb_rec.ctrl.load_cc;
    assign wb.dest = wb_rec.dest;
    assign wb.data = wb_rec.alu_out;

    assign fwd.src1_ex = ex_rec.src1;
    assign fwd.src2_ex = ex_rec.src2;
    assign fwd.mem_dest = mem_rec.dest;
    assign fwd.mem_load_regfile = mem_rec.valid && mem_rec.ctrl.load_regfile;
    assign fwd.mem_data = mem_result;
    assign fwd.wb_dest = wb_rec.dest;
    assign fwd.wb_load_regfile = wb_rec.valid && wb_rec.ctrl.load_regfile;
    assign fwd.wb_data = wb_rec.alu_out;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            pc <= `LC3B_RESET_PC;
            de_rec.valid <= 1'b0;
            ex_rec.valid <= 1'b0;
            mem_rec.valid <= 1'b0;
            wb_rec.valid <= 1'b0;
        end else if (advance) begin
            if (flush) begin
                pc <= wb_rec.addr;
                de_rec.valid <= 1'b0;
                ex_rec.valid <= 1'b0;
                mem_rec.valid <= 1'b0;
                wb_rec.valid <= 1'b0;
            end else begin
                pc <= pc_plus2;
                de_rec <= fetch_out;
                ex_rec <= decode_out;
                mem_rec <= exec_out;
                wb_rec <= memory_out;
            end
        end
    end

    assign o_i_mem_read = i_rst_n;
    assign o_i_mem_address = pc;

    d_rd_wr_excl: assert property (@(posedge clk) !(o_d_mem_read && o_d_mem_write))
        else $error("data port read and write both high");

    d_addr_stable: assert property (@(posedge clk) disable iff (!i_rst_n)
        mem_busy && !i_d_mem_resp |=> mem_busy && $stable(o_d_mem_address))
        else $error("data request changed before its response");

    no_valid_in_reset: assert property (@(posedge clk)
        !i_rst_n |=> !(de_rec.valid || ex_rec.valid || mem_rec.valid || wb_rec.valid))
        else $error("pipeline record valid during reset");

endmodule

/* lc3b_execute.sv */
module lc3b_execute (
    input  lc3b_pkg::lc3b_stage i_rec,
    fwd_if.exec                 fwd,
    output lc3b_pkg::lc3b_word  o_alu_out,
    output lc3b_pkg::lc3b_word  o_store_data,
    output lc3b_pkg::lc3b_word  o_br_target
);

    lc3b_pkg::lc3b_word op_a;
    lc3b_pkg::lc3b_word op_b_reg;
    lc3b_pkg::lc3b_word op_b;
    lc3b_pkg::lc3b_word imm5_sext;
    lc3b_pkg::lc3b_word off6_adj;
    lc3b_pkg::lc3b_word off9_adj;

    function automatic lc3b_pkg::lc3b_word fwd_mux(
        input lc3b_pkg::lc3b_fwd_sel sel,
        input lc3b_pkg::lc3b_word    reg_val,
        input lc3b_pkg::lc3b_word    mem_val,
        input lc3b_pkg::lc3b_word    wb_val
    );
        lc3b_pkg::lc3b_word val;
        case (sel)
            lc3b_pkg::fwd_mem: val = mem_val;
            lc3b_pkg::fwd_wb:  val = wb_val;
            default:           val = reg_val;
        endcase
        return val;
    endfunction

    assign op_a = fwd_mux(fwd.sel_a, i_rec.src1_data, fwd.mem_data, fwd.wb_data);
    assign op_b_reg = fwd_mux(fwd.sel_b, i_rec.src2_data, fwd.mem_data, fwd.wb_data);

    // Offsets are word offsets, scaled to bytes
    assign imm5_sext = lc3b_pkg::lc3b_word'(signed'(i_rec.instr.op.tail));
    assign off6_adj = lc3b_pkg::lc3b_word'(signed'({i_rec.instr.op.imm,
                                                    i_rec.instr.op.tail})) << 1;
    assign off9_adj = lc3b_pkg::lc3b_word'(signed'(i_rec.instr.br.offset9)) << 1;

    always_comb begin
        case (i_rec.ctrl.alumux_sel)
            lc3b_pkg::mux_imm5: op_b = imm5_sext;
            lc3b_pkg::mux_off6: op_b = off6_adj;
            default:            op_b = op_b_reg;
        endcase
    end

    always_comb begin
        case (i_rec.ctrl.aluop)
            lc3b_pkg::alu_add: o_alu_out = op_a + op_b;
            lc3b_pkg::alu_and: o_alu_out = op_a & op_b;
            lc3b_pkg::alu_not: o_alu_out = ~op_a;
            default:           o_alu_out = op_a;
        endcase
    end

    // STR data is the forwarded SR read through src2
    assign o_store_data = op_b_reg;
    assign o_br_target = i_rec.pc_plus2 + off9_adj;

endmodule

/* lc3b_forwarding_unit.sv */
module lc3b_forwarding_unit (
    fwd_if.unit fwd
);

    // Youngest producer wins, so memory is checked before writeback
    function automatic lc3b_pkg::lc3b_fwd_sel pick_source(
        input lc3b_pkg::lc3b_reg src,
        input lc3b_pkg::lc3b_reg mem_dest,
        input logic              mem_load,
        input lc3b_pkg::lc3b_reg wb_dest,
        input logic              wb_load
    );
        lc3b_pkg::lc3b_fwd_sel sel;
        sel = lc3b_pkg::fwd_reg;
        if (mem_load && mem_dest == src) begin
            sel = lc3b_pkg::fwd_mem;
        end else if (wb_load && wb_dest == src) begin
            sel = lc3b_pkg::fwd_wb;
        end
        return sel;
    endfunction

    assign fwd.sel_a = pick_source(fwd.src1_ex, fwd.mem_dest, fwd.mem_load_regfile,
                                   fwd.wb_dest, fwd.wb_load_regfile);
    assign fwd.sel_b = pick_source(fwd.src2_ex, fwd.mem_dest, fwd.mem_load_regfile,
                                   fwd.wb_dest, fwd.wb_load_regfile);

    always_comb begin
        sel_range: assert (fwd.sel_a inside {lc3b_pkg::fwd_reg, lc3b_pkg::fwd_mem,
                                             lc3b_pkg::fwd_wb} &&
                           fwd.sel_b inside {lc3b_pkg::fwd_reg, lc3b_pkg::fwd_mem,
                                             lc3b_pkg::fwd_wb})
            else $error("forwarding select out of range");
    end

endmodule

/* lc3b_if.sv */
// Register and cc update from the writeback stage
interface wb_if;
    logic               valid;
    logic               load_regfile;
    logic               load_cc;
    lc3b_pkg::lc3b_reg  dest;
    lc3b_pkg::lc3b_word data;

    modport sink (input valid, load_regfile, load_cc, dest, data);
endinterface

// Producer info from memory and writeback for the execute operands
interface fwd_if;
    lc3b_pkg::lc3b_reg     src1_ex;
    lc3b_pkg::lc3b_reg     src2_ex;
    lc3b_pkg::lc3b_reg     mem_dest;
    logic                  mem_load_regfile;
    lc3b_pkg::lc3b_word    mem_data;
    lc3b_pkg::lc3b_reg     wb_dest;
    logic                  wb_load_regfile;
    lc3b_pkg::lc3b_word    wb_data;
    lc3b_pkg::lc3b_fwd_sel sel_a;
    lc3b_pkg::lc3b_fwd_sel sel_b;

    modport unit (
        input  src1_ex, src2_ex, mem_dest, mem_load_regfile, wb_dest, wb_load_regfile,
        output sel_a, sel_b
    );
    modport exec (input sel_a, sel_b, mem_data, wb_data);
endinterface

/* lc3b_pkg.sv */
`include "lc3b_settings.svh"

package lc3b_pkg;

    typedef logic [`LC3B_WORD_W-1:0] lc3b_word;
    typedef logic [2:0] lc3b_reg;

    // N in bit 2, Z in bit 1, P in bit 0
    typedef logic [2:0] lc3b_nzp;

    // Supported subset, everything else runs as a no-op
    typedef enum logic [3:0] {
        op_br  = 4'b0000,
        op_add = 4'b0001,
        op_and = 4'b0101,
        op_ldr = 4'b0110,
        op_str = 4'b0111,
        op_not = 4'b1001
    } lc3b_opcode;

    typedef enum logic [1:0] {
        alu_add,
        alu_and,
        alu_not,
        alu_pass
    } lc3b_aluop;

    typedef enum logic [1:0] {
        mux_reg,
        mux_imm5,
        mux_off6
    } lc3b_alumux_sel;

    // Operand source picked by the forwarding unit
    typedef enum logic [1:0] {
        fwd_reg,
        fwd_mem,
        fwd_wb
    } lc3b_fwd_sel;

    // Tail is imm5, or offset6[4:0] with imm as offset6[5]
    typedef union packed {
        struct packed {
            lc3b_opcode opcode;
            lc3b_reg    dest;
            lc3b_reg    src1;
            logic       imm;
            logic [4:0] tail;
        } op;
        struct packed {
            lc3b_opcode opcode;
            lc3b_nzp    nzp;
            logic [8:0] offset9;
        } br;
    } lc3b_instr;

    typedef struct packed {
        lc3b_opcode     opcode;
        lc3b_aluop      aluop;
        lc3b_alumux_sel alumux_sel;
        logic           load_regfile;
        logic           load_cc;
        logic           d_mem_read;
        logic           d_mem_write;
        logic           use_src2;
    } lc3b_ctrl;

    typedef struct packed {
        logic      valid;
        lc3b_ctrl  ctrl;
        lc3b_instr instr;
        lc3b_word  pc_plus2;
        lc3b_reg   dest;
        lc3b_reg   src1;
        lc3b_reg   src2;
        lc3b_word  src1_data;
        lc3b_word  src2_data;
        lc3b_word  alu_out;
        lc3b_word  addr;
    } lc3b_stage;

endpackage

/* lc3b_regfile.sv */
`include "lc3b_settings.svh"

module lc3b_regfile (
    input  logic               clk,
    input  logic               i_rst_n,
    input  lc3b_pkg::lc3b_reg  i_src1,
    input  lc3b_pkg::lc3b_reg  i_src2,
    input  lc3b_pkg::lc3b_nzp  i_br_nzp,
    wb_if.sink                 wb,
    output lc3b_pkg::lc3b_word o_src1_data,
    output lc3b_pkg::lc3b_word o_src2_data,
    output logic               o_br_enable
);

    lc3b_pkg::lc3b_word regs [`LC3B_REG_CNT];
    lc3b_pkg::lc3b_nzp  cc;
    lc3b_pkg::lc3b_nzp  gencc;
    logic               wr_en;

    assign wr_en = wb.valid && wb.load_regfile;

    always_comb begin
        if (wb.data[`LC3B_WORD_W-1]) begin
            gencc = 3'b100;
        end else if (wb.data == '0) begin
            gencc = 3'b010;
        end else begin
            gencc = 3'b001;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < `LC3B_REG_CNT; i++) begin
                regs[i] <= '0;
            end
            cc <= 3'b010;
        end else begin
            if (wr_en) begin
                regs[wb.dest] <= wb.data;
            end
            if (wb.valid && wb.load_cc) begin
                cc <= gencc;
            end
        end
    end

    // Decode sees the value written at this same edge
    assign o_src1_data = (wr_en && wb.dest == i_src1) ? wb.data : regs[i_src1];
    assign o_src2_data = (wr_en && wb.dest == i_src2) ? wb.data : regs[i_src2];

    assign o_br_enable = |(i_br_nzp & cc);

    cc_onehot: assert property (@(posedge clk) disable iff (!i_rst_n) $onehot(cc))
        else $error("cc register lost its one-hot value");

endmodule

/* lc3b_settings.svh */
`ifndef LC3B_SETTINGS_SVH
`define LC3B_SETTINGS_SVH

// Data and address width
`define LC3B_WORD_W 16

// General purpose registers R0 to R7
`define LC3B_REG_CNT 8

// First fetch address out of reset
`define LC3B_RESET_PC 16'h0000

`endif

/* run.sh */
#!/bin/sh
# Build and run the LC-3b pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_lc3b -f src.f -o tb_lc3b_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_lc3b_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if grep -q "Simulation FAILED" sim.log; then
    exit 1
fi
exit 0

/* src.f */
+incdir+.
lc3b_pkg.sv
lc3b_if.sv
lc3b_control_rom.sv
lc3b_regfile.sv
lc3b_forwarding_unit.sv
lc3b_execute.sv
lc3b_datapath.sv
tb_lc3b_checker.sv
tb_lc3b.sv

/* tb_lc3b.sv */
module tb_lc3b;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk;
    logic        i_rst_n;
    logic        i_i_mem_resp;
    logic [15:0] i_i_mem_rdata;
    logic        i_d_mem_resp;
    logic [15:0] i_d_mem_rdata;
    logic        o_i_mem_read;
    logic [15:0] o_i_mem_address;
    logic        o_d_mem_read;
    logic        o_d_mem_write;
    logic [15:0] o_d_mem_address;
    logic [15:0] o_d_mem_wdata;

    logic [15:0] prog [1024];
    int          prog_len;
    logic        prog_ready;
    integer      seed;
    logic [15:0] dmem [logic [15:0]];
    int          i_wait;
    int          d_wait;
    logic        chk_done;
    int          chk_errors;
    int          chk_tests_failed;
    int          chk_checks;
    int          cycles;

    lc3b_datapath dut (.*);

    tb_lc3b_checker u_checker (
        .clk, .i_rst_n,
        .i_prog_ready(prog_ready), .i_prog(prog), .i_prog_len(prog_len),
        .i_fetch_addr(o_i_mem_address), .i_i_read(o_i_mem_read),
        .i_d_read(o_d_mem_read), .i_d_write(o_d_mem_write), .i_d_resp(i_d_mem_resp),
        .i_d_addr(o_d_mem_address), .i_d_wdata(o_d_mem_wdata),
        .o_done(chk_done), .o_errors(chk_errors),
        .o_tests_failed(chk_tests_failed), .o_checks(chk_checks)
    );

    function automatic logic [15:0] fetch_word(input logic [15:0] addr);
        // Past the program the fetch sees BR with nzp 000
        return (addr < 16'd2048) ? prog[addr[10:1]] : 16'h0000;
    endfunction

    task automatic build_program();
        int n;
        int kind;
        logic prev_br;
        logic [2:0] d;
        logic [2:0] s1;
        logic [2:0] s2;
        logic imm;
        n = 3;
        prev_br = 1'b0;
        for (int a = 0; a < 1024; a++) begin
            prog[a] = 16'h0000;
        end
        // R0 becomes the base 30 for every LDR and STR
        prog[0] = {4'b0101, 3'd0, 3'd0, 1'b1, 5'd0};
        prog[1] = {4'b0001, 3'd0, 3'd0, 1'b1, 5'd15};
        prog[2] = {4'b0001, 3'd0, 3'd0, 1'b1, 5'd15};
        while (n < 203) begin
            kind = int'($unsigned($random(seed)) % 10);
            d = 3'd1 + 3'($unsigned($random(seed)) % 7);
            s1 = 3'($random(seed));
            s2 = 3'($random(seed));
            imm = 1'($random(seed));
            // A store right behind a BR sits in memory while the BR resolves
            if (prev_br && (kind == 5 || kind == 6)) begin
                kind = 0;
            end
            case (kind)
                0, 1: prog[n] = {4'b0001, d, s1, imm, imm ? 5'($random(seed)) : {2'b00, s2}};
                2: prog[n] = {4'b0101, d, s1, imm, imm ? 5'($random(seed)) : {2'b00, s2}};
                3: prog[n] = {4'b1001, d, s1, 6'b111111};
                4: prog[n] = {4'b0110, d, 3'd0, 6'($random(seed))};
                5, 6: prog[n] = {4'b0111, s1, 3'd0, 6'($random(seed))};
                7, 8: prog[n] = {4'b0000, 3'($random(seed)),
                                 9'd1 + 9'($unsigned($random(seed)) % 4)};
                default: begin
                    // Load, dependent add, store of the sum
                    prog[n] = {4'b0110, d, 3'd0, 6'($random(seed))};
                    n++;
                    prog[n] = {4'b0001, s2 | 3'd1, d, 1'b1, 5'($random(seed))};
                    n++;
                    prog[n] = {4'b0111, s2 | 3'd1, 3'd0, 6'($random(seed))};
                end
            endcase
            prev_br = (kind == 7 || kind == 8);
            n++;
        end
        // Four no-ops keep the last branches from skipping the dump
        n = n + 4;
        for (int r = 1; r < 8; r++) begin
            prog[n] = {4'b0111, 3'(r), 3'd0, 6'(24 + r)};
            n++;
        end
        prog_len = n;
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Memory models hold each answer for one cycle
    always @(posedge clk) begin
        if (!i_rst_n) begin
            i_i_mem_resp <= 1'b0;
            i_d_mem_resp <= 1'b0;
        end else begin
            if (i_i_mem_resp) begin
                i_i_mem_resp <= 1'b0;
            end else if (o_i_mem_read) begin
                if (i_wait == 0) begin
                    i_i_mem_resp <= 1'b1;
                    i_i_mem_rdata <= fetch_word(o_i_mem_address);
                    i_wait <= int'($unsigned($random(seed)) % 4);
                end else begin
                    i_wait <= i_wait - 1;
                end
            end
            if (i_d_mem_resp) begin
                i_d_mem_resp <= 1'b0;
            end else if (o_d_mem_read || o_d_mem_write) begin
                if (d_wait == 0) begin
                    i_d_mem_resp <= 1'b1;
                    if (o_d_mem_write) begin
                        dmem[o_d_mem_address] = o_d_mem_wdata;
                    end else begin
                        i_d_mem_rdata <= dmem.exists(o_d_mem_address) ?
                            dmem[o_d_mem_address] : o_d_mem_address ^ 16'h5a5a;
                    end
                    d_wait <= int'($unsigned($random(seed)) % 4);
                end else begin
                    d_wait <= d_wait - 1;
                end
            end
        end
    end

    initial begin
        seed = 32'h2ba1865f;
        i_rst_n = 1'b0;
        i_i_mem_resp = 1'b0;
        i_i_mem_rdata = 16'h0000;
        i_d_mem_resp = 1'b0;
        i_d_mem_rdata = 16'h0000;
        i_wait = 0;
        d_wait = 0;
        prog_ready = 1'b0;
        build_program();
        prog_ready = 1'b1;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        cycles = 0;
        while (!chk_done && cycles < 200000) begin
            @(posedge clk);
            cycles++;
        end
        if (!chk_done) begin
            $display("Checker did not finish within 200000 cycles");
            $display("Simulation FAILED");
        end else begin
            $display("Tests: %0d passed, %0d failed, %0d checks, %0d errors",
                     5 - chk_tests_failed, chk_tests_failed, chk_checks, chk_errors);
            if (chk_errors == 0) begin
                $display("Simulation PASSED");
            end else begin
                $display("Simulation FAILED");
            end
        end
        $finish;
    end

endmodule

/* tb_lc3b_checker.sv */
module tb_lc3b_checker (
    input  logic        clk,
    input  logic        i_rst_n,
    input  logic        i_prog_ready,
    input  logic [15:0] i_prog [1024],
    input  int          i_prog_len,
    input  logic [15:0] i_fetch_addr,
    input  logic        i_i_read,
    input  logic        i_d_read,
    input  logic        i_d_write,
    input  logic        i_d_resp,
    input  logic [15:0] i_d_addr,
    input  logic [15:0] i_d_wdata,
    output logic        o_done,
    output int          o_errors,
    output int          o_tests_failed,
    output int          o_checks
);
    timeunit 1ns;
    timeprecision 1ps;

    logic [15:0] exp_addr [$];
    logic [15:0] exp_data [$];
    int          exp_tag [$];
    logic [15:0] act_addr [$];
    logic [15:0] act_data [$];
    int          err [1:5];
    int          checked [1:5];
    int          reset_err;
    int          cycles;
    int          t;

    // Writes commit on the edge that sees the response
    always @(posedge clk) begin
        if (!i_rst_n && (i_i_read || i_d_read || i_d_write)) begin
            $display("Memory port request raised during reset");
            reset_err++;
        end
        if (i_rst_n && i_d_write && i_d_resp) begin
            act_addr.push_back(i_d_addr);
            act_data.push_back(i_d_wdata);
        end
    end

    function automatic logic [15:0] sext(input logic [15:0] v, input int bits);
        logic [15:0] m;
        m = 16'hffff << bits;
        return v[bits-1] ? (v | m) : (v & ~m);
    endfunction

    function automatic logic [2:0] setcc(input logic [15:0] v);
        return v[15] ? 3'b100 : (v == 16'h0000) ? 3'b010 : 3'b001;
    endfunction

    // Tag 2 is ALU data, 3 is load dependent data, 5 is the register dump
    task automatic run_model();
        logic [15:0] r [8];
        logic [15:0] mem [logic [15:0]];
        logic        ld_direct [8];
        logic        ld_dep [8];
        logic [2:0]  cc;
        logic [15:0] pc;
        logic [15:0] ir;
        logic [15:0] b;
        logic [15:0] res;
        logic [15:0] addr;
        logic        dep;
        int          steps;
        for (int i = 0; i < 8; i++) begin
            r[i] = 16'h0000;
            ld_direct[i] = 1'b0;
            ld_dep[i] = 1'b0;
        end
        cc = 3'b010;
        pc = 16'h0000;
        steps = 0;
        while (int'(pc >> 1) < i_prog_len && steps < 10000) begin
            ir = i_prog[pc[10:1]];
            pc = pc + 16'd2;
            steps++;
            b = ir[5] ? sext(ir, 5) : r[ir[2:0]];
            addr = r[ir[8:6]] + (sext(ir, 6) << 1);
            case (ir[15:12])
                4'b0001, 4'b0101, 4'b1001: begin
                    if (ir[15:12] == 4'b0001) begin
                        res = r[ir[8:6]] + b;
                    end else if (ir[15:12] == 4'b0101) begin
                        res = r[ir[8:6]] & b;
                    end else begin
                        res = ~r[ir[8:6]];
                    end
                    dep = ld_direct[ir[8:6]] || (!ir[5] && ld_direct[ir[2:0]]);
                    ld_dep[ir[11:9]] = dep;
                    ld_direct[ir[11:9]] = 1'b0;
                    r[ir[11:9]] = res;
                    cc = setcc(res);
                end
                4'b0110: begin
                    res = mem.exists(addr) ? mem[addr] : addr ^ 16'h5a5a;
                    r[ir[11:9]] = res;
                    ld_direct[ir[11:9]] = 1'b1;
                    ld_dep[ir[11:9]] = 1'b1;
                    cc = setcc(res);
                end
                4'b0111: begin
                    mem[addr] = r[ir[11:9]];
                    exp_addr.push_back(addr);
                    exp_data.push_back(r[ir[11:9]]);
                    if (int'(pc >> 1) > i_prog_len - 7) begin
                        exp_tag.push_back(5);
                    end else begin
                        exp_tag.push_back(ld_dep[ir[11:9]] ? 3 : 2);
                    end
                end
                4'b0000: begin
                    if ((ir[11:9] & cc) != 3'b000) begin
                        pc = pc + (sext(ir, 9) << 1);
                    end
                end
                default: begin
                end
            endcase
        end
    endtask

    task automatic report(input int n, input string name);
        $display("Test %0d %s: %0d checks, %0d errors, %s", n, name, checked[n], err[n],
                 (err[n] == 0) ? "ok" : "mismatches found");
    endtask

    initial begin
        o_done = 1'b0;
        reset_err = 0;
        for (int i = 1; i <= 5; i++) begin
            err[i] = 0;
            checked[i] = 0;
        end
        cycles = 0;
        while (!(i_rst_n === 1'b1 && i_prog_ready === 1'b1) && cycles < 2000) begin
            @(posedge clk);
            cycles++;
        end
        checked[1] = 3;
        if (!(i_rst_n === 1'b1 && i_prog_ready === 1'b1)) begin
            $display("Timed out waiting for reset to be released");
            err[1]++;
        end else begin
            if (i_fetch_addr !== 16'h0000) begin
                $display("FAIL test 1: o_i_mem_address expected 0x%h actual 0x%h",
                         16'h0000, i_fetch_addr);
                err[1]++;
            end
            if (i_i_read !== 1'b1) begin
                $display("FAIL test 1: o_i_mem_read expected 0x%h actual 0x%h",
                         1'b1, i_i_read);
                err[1]++;
            end
        end
        err[1] = err[1] + reset_err;
        report(1, "reset");

        run_model();
        for (int k = 0; k < exp_addr.size(); k++) begin
            cycles = 0;
            while (act_addr.size() <= k && cycles < 2000) begin
                @(posedge clk);
                cycles++;
            end
            if (act_addr.size() <= k) begin
                $display("Timed out waiting for data write %0d of %0d", k + 1, exp_addr.size());
                err[4]++;
                break;
            end
            t = exp_tag[k];
            checked[t]++;
            if (t != 5) begin
                checked[4]++;
            end
            if (act_addr[k] !== exp_addr[k]) begin
                $display("FAIL test %0d: o_d_mem_address expected 0x%h actual 0x%h at write %0d",
                         (t == 5) ? 5 : 4, exp_addr[k], act_addr[k], k);
                err[(t == 5) ? 5 : 4]++;
            end
            if (act_data[k] !== exp_data[k]) begin
                $display("FAIL test %0d: o_d_mem_wdata expected 0x%h actual 0x%h at write %0d",
                         t, exp_data[k], act_data[k], k);
                err[t]++;
            end
        end

        // Quiet window catches writes beyond the model's count
        cycles = 0;
        while (act_addr.size() == exp_addr.size() && cycles < 100) begin
            @(posedge clk);
            cycles++;
        end
        checked[5]++;
        if (act_addr.size() != exp_addr.size()) begin
            $display("FAIL test 5: write count expected 0x%h actual 0x%h",
                     exp_addr.size(), act_addr.size());
            err[5]++;
        end
        report(2, "alu chains");
        report(3, "load use");
        report(4, "branch shadows");
        report(5, "register dump");

        o_errors = 0;
        o_tests_failed = 0;
        o_checks = 0;
        for (int i = 1; i <= 5; i++) begin
            o_errors = o_errors + err[i];
            o_checks = o_checks + checked[i];
            if (err[i] != 0) begin
                o_tests_failed++;
            end
        end
        o_done = 1'b1;
    end

endmodule
